//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;   // Data and address word
    typedef logic [3:0]  reg_idx_t;

    // Primary opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        ALUR = 6'b000000,
        BEQ  = 6'b001000,
        BLT  = 6'b001001,
        BLE  = 6'b001010,
        BNE  = 6'b001011,
        JAL  = 6'b001100,
        SW   = 6'b011010,
        ADDI = 6'b100000,
        ANDI = 6'b100100,
        ORI  = 6'b100101,
        XORI = 6'b100110
    } opcode_t;

    // Secondary codes for ALUR, bits 25:18
    typedef enum logic [7:0] {
        EQ   = 8'b00001000,
        LT   = 8'b00001001,
        LE   = 8'b00001010,
        NE   = 8'b00001011,
        ADD  = 8'b00100000,
        AND  = 8'b00100100,
        OR   = 8'b00100101,
        XOR  = 8'b00100110,
        SUB  = 8'b00101000,
        NAND = 8'b00101100,
        NOR  = 8'b00101101,
        NXOR = 8'b00101110,
        RSHF = 8'b00110000,
        LSHF = 8'b00110001
    } func_t;

    // Immediate overlaps func and spare, bits 23:8
    typedef struct packed {
        opcode_t    opcode;
        func_t      func;
        logic [5:0] spare;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
    } inst_t;

    localparam word_t INST_BYTES = 32'd4;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic imm_src;    // Second operand is the immediate
        logic reg_we;
        logic link_sel;   // Write link PC instead of ALU result
        logic mem_we;
        logic is_branch;
        logic is_jal;
    } ctrl_t;

    // Decode to execute latch
    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        isa_pkg::opcode_t  opcode;
        isa_pkg::func_t    func;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    rs_val;
        isa_pkg::word_t    rt_val;
        isa_pkg::word_t    imm;       // Sign extended
        isa_pkg::word_t    link_pc;   // Address after this instruction
    } id_ex_t;

    // Execute to memory latch
    typedef struct packed {
        logic              valid;
        logic              reg_we;
        logic              mem_we;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    result;    // Also the store address
        isa_pkg::word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    data;
    } wb_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t target;
    } redirect_t;

    // Wishbone master outputs
    typedef struct packed {
        logic           cyc;
        logic           stb;
        logic           we;
        isa_pkg::word_t adr;
        isa_pkg::word_t dat;
        logic [3:0]     sel;
    } wb_req_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
    parameter isa_pkg::word_t START_PC = 32'h100
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                freeze,
    input  pipe_pkg::redirect_t redirect,
    input  isa_pkg::word_t      inst,
    output isa_pkg::word_t      inst_addr,
    output isa_pkg::inst_t      fe_inst,
    output logic                fe_valid,
    output isa_pkg::word_t      fe_next_pc
);

    isa_pkg::word_t pc;
    logic           advance;

    assign inst_addr = pc;   // Instruction returns in the same cycle
    assign advance   = !freeze && !redirect.valid && !stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= START_PC;
            fe_valid <= 1'b0;
        end else if (!freeze) begin
            if (redirect.valid) begin
                pc       <= redirect.target;
                fe_valid <= 1'b0;   // Drop the wrong-path fetch
            end else if (!stall) begin
                pc       <= pc + isa_pkg::INST_BYTES;
                fe_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fe_inst    <= isa_pkg::inst_t'(inst);
            fe_next_pc <= pc + isa_pkg::INST_BYTES;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                freeze,
    input  pipe_pkg::redirect_t redirect,
    input  isa_pkg::inst_t      fe_inst,
    input  logic                fe_valid,
    input  isa_pkg::word_t      fe_next_pc,
    input  isa_pkg::word_t      rs_val,
    input  isa_pkg::word_t      rt_val,
    output isa_pkg::reg_idx_t   rs_idx,
    output isa_pkg::reg_idx_t   rt_idx,
    output logic                stall,
    output pipe_pkg::id_ex_t    id_ex
);

    pipe_pkg::ctrl_t   ctrl;
    isa_pkg::reg_idx_t dst;
    isa_pkg::word_t    imm;
    logic              uses_rt;
    logic              rs_hit;
    logic              rt_hit;
    logic              ex_we_q;    // Copy of the execute latch destination
    isa_pkg::reg_idx_t ex_dst_q;

    assign rs_idx = fe_inst.rs;
    assign rt_idx = fe_inst.rt;
    assign imm    = {{16{fe_inst[23]}}, fe_inst[23:8]};

    always_comb begin
        ctrl    = '0;
        uses_rt = 1'b0;
        case (fe_inst.opcode)
            isa_pkg::ALUR: begin
                ctrl.reg_we = 1'b1;
                uses_rt     = 1'b1;
            end
            isa_pkg::BEQ, isa_pkg::BLT, isa_pkg::BLE, isa_pkg::BNE: begin
                ctrl.is_branch = 1'b1;
                uses_rt        = 1'b1;
            end
            isa_pkg::JAL: begin
                ctrl.reg_we   = 1'b1;
                ctrl.link_sel = 1'b1;
                ctrl.is_jal   = 1'b1;
            end
            isa_pkg::SW: begin
                ctrl.imm_src = 1'b1;
                ctrl.mem_we  = 1'b1;
                uses_rt      = 1'b1;   // Store data
            end
            isa_pkg::ADDI, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI: begin
                ctrl.imm_src = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            default: ;   // Unknown opcode runs as a no-op
        endcase
        dst = (fe_inst.opcode == isa_pkg::ALUR) ? fe_inst.rd : fe_inst.rt;
        if (dst == '0)
            ctrl.reg_we = 1'b0;   // r0 never written
    end

    // RAW check against the two older writers
    assign rs_hit = (fe_inst.rs != '0) &&
                    ((id_ex.valid && id_ex.ctrl.reg_we && id_ex.dst == fe_inst.rs) ||
                     (ex_we_q && ex_dst_q == fe_inst.rs));
    assign rt_hit = (fe_inst.rt != '0) &&
                    ((id_ex.valid && id_ex.ctrl.reg_we && id_ex.dst == fe_inst.rt) ||
                     (ex_we_q && ex_dst_q == fe_inst.rt));
    assign stall  = fe_valid && (rs_hit || (uses_rt && rt_hit));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex    <= '0;
            ex_we_q  <= 1'b0;
            ex_dst_q <= '0;
        end else if (!freeze) begin
            ex_we_q  <= id_ex.valid && id_ex.ctrl.reg_we;
            ex_dst_q <= id_ex.dst;
            if (redirect.valid || stall || !fe_valid) begin
                id_ex <= '0;   // Bubble
            end else begin
                id_ex.valid   <= 1'b1;
                id_ex.ctrl    <= ctrl;
                id_ex.opcode  <= fe_inst.opcode;
                id_ex.func    <= fe_inst.func;
                id_ex.dst     <= dst;
                id_ex.rs_val  <= rs_val;
                id_ex.rt_val  <= rt_val;
                id_ex.imm     <= imm;
                id_ex.link_pc <= fe_next_pc;
            end
        end
    end

    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        id_ex.valid && id_ex.ctrl.reg_we |-> id_ex.dst != '0)
        else $error("Decode latch writes register 0");

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    output isa_pkg::word_t    rs_val,
    output isa_pkg::word_t    rt_val,
    input  pipe_pkg::wb_t     wb
);

    isa_pkg::word_t regs [16];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wb.we && wb.dst != '0) begin
            regs[wb.dst] <= wb.data;
        end
    end

    // Write-through so decode sees this cycle's writeback
    assign rs_val = (rs_idx == '0) ? '0 :
                    (wb.we && wb.dst == rs_idx) ? wb.data : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 :
                    (wb.we && wb.dst == rt_idx) ? wb.data : regs[rt_idx];

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 freeze,
    input  pipe_pkg::id_ex_t     id_ex,
    output pipe_pkg::redirect_t  redirect,
    output pipe_pkg::ex_mem_t    ex_mem
);

    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t alu;
    logic           taken;

    assign a = id_ex.rs_val;
    assign b = id_ex.ctrl.imm_src ? id_ex.imm : id_ex.rt_val;

    always_comb begin
        case (id_ex.opcode)
            isa_pkg::ALUR: begin
                case (id_ex.func)
                    isa_pkg::EQ:   alu = {31'b0, a == b};
                    isa_pkg::LT:   alu = {31'b0, $signed(a) < $signed(b)};
                    isa_pkg::LE:   alu = {31'b0, $signed(a) <= $signed(b)};
                    isa_pkg::NE:   alu = {31'b0, a != b};
                    isa_pkg::ADD:  alu = a + b;
                    isa_pkg::AND:  alu = a & b;
                    isa_pkg::OR:   alu = a | b;
                    isa_pkg::XOR:  alu = a ^ b;
                    isa_pkg::SUB:  alu = a - b;
                    isa_pkg::NAND: alu = ~(a & b);
                    isa_pkg::NOR:  alu = ~(a | b);
                    isa_pkg::NXOR: alu = ~(a ^ b);
                    isa_pkg::RSHF: alu = $signed(a) >>> b;   // Sign fill
                    isa_pkg::LSHF: alu = a << b;
                    default:       alu = '0;
                endcase
            end
            isa_pkg::ADDI, isa_pkg::SW: alu = a + b;   // SW forms its address here
            isa_pkg::ANDI:              alu = a & b;
            isa_pkg::ORI:               alu = a | b;
            isa_pkg::XORI:              alu = a ^ b;
            default:                    alu = '0;
        endcase
    end

    // Signed compare of rs against rt
    always_comb begin
        case (id_ex.opcode)
            isa_pkg::BEQ: taken = a == id_ex.rt_val;
            isa_pkg::BLT: taken = $signed(a) < $signed(id_ex.rt_val);
            isa_pkg::BLE: taken = $signed(a) <= $signed(id_ex.rt_val);
            isa_pkg::BNE: taken = a != id_ex.rt_val;
            default:      taken = 1'b0;
        endcase
    end

    assign redirect.valid  = id_ex.valid &&
                             ((id_ex.ctrl.is_branch && taken) || id_ex.ctrl.is_jal);
    assign redirect.target = id_ex.ctrl.is_jal ? a + (id_ex.imm << 2)
                                               : id_ex.link_pc + (id_ex.imm << 2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.reg_we     <= id_ex.ctrl.reg_we;
            ex_mem.mem_we     <= id_ex.ctrl.mem_we;
            ex_mem.dst        <= id_ex.dst;
            ex_mem.result     <= id_ex.ctrl.link_sel ? id_ex.link_pc : alu;
            ex_mem.store_data <= id_ex.rt_val;
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::wb_req_t wb_req,
    input  logic              wb_ack,
    output logic              freeze,
    output pipe_pkg::wb_t     wb
);

    logic           req_q;    // Bus cycle in progress
    logic           store;
    isa_pkg::word_t adr_q;
    isa_pkg::word_t dat_q;

    assign store  = ex_mem.valid && ex_mem.mem_we;
    assign freeze = req_q && !wb_ack;   // Hold everything until ack

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            req_q <= 1'b0;
        else if (!freeze)
            req_q <= store;   // Back-to-back store keeps the cycle up
    end

    always_ff @(posedge clk) begin
        if (!freeze && store) begin
            adr_q <= ex_mem.result;
            dat_q <= ex_mem.store_data;
        end
    end

    assign wb_req.cyc = req_q;
    assign wb_req.stb = req_q;
    assign wb_req.we  = req_q;
    assign wb_req.adr = adr_q;
    assign wb_req.dat = dat_q;
    assign wb_req.sel = 4'hf;   // Full word only

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else if (!freeze) begin
            wb.we   <= ex_mem.valid && ex_mem.reg_we;
            wb.dst  <= ex_mem.dst;
            wb.data <= ex_mem.result;
        end
    end

    stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc)
        else $error("Wishbone stb without cyc");

    req_stable: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.dat))
        else $error("Wishbone request changed before ack");

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
    parameter isa_pkg::word_t START_PC = 32'h100
) (
    input  logic              clk,
    input  logic              reset,
    output isa_pkg::word_t    inst_addr,
    input  isa_pkg::word_t    inst,
    output pipe_pkg::wb_req_t wb_req,
    input  logic              wb_ack
);

    logic                stall;
    logic                freeze;    // Outstanding store
    pipe_pkg::redirect_t redirect;
    isa_pkg::inst_t      fe_inst;
    logic                fe_valid;
    isa_pkg::word_t      fe_next_pc;
    isa_pkg::reg_idx_t   rs_idx;
    isa_pkg::reg_idx_t   rt_idx;
    isa_pkg::word_t      rs_val;
    isa_pkg::word_t      rt_val;
    pipe_pkg::id_ex_t    id_ex;
    pipe_pkg::ex_mem_t   ex_mem;
    pipe_pkg::wb_t       wb;

    fetch_stage #(.START_PC(START_PC)) u_fetch (
        .clk, .reset, .stall, .freeze, .redirect, .inst,
        .inst_addr, .fe_inst, .fe_valid, .fe_next_pc
    );

    decode_stage u_decode (
        .clk, .reset, .freeze, .redirect,
        .fe_inst, .fe_valid, .fe_next_pc,
        .rs_val, .rt_val, .rs_idx, .rt_idx, .stall, .id_ex
    );

    reg_file u_regs (
        .clk, .reset, .rs_idx, .rt_idx, .rs_val, .rt_val, .wb
    );

    execute_stage u_execute (
        .clk, .reset, .freeze, .id_ex, .redirect, .ex_mem
    );

    memory_stage u_memory (
        .clk, .reset, .ex_mem, .wb_req, .wb_ack, .freeze, .wb
    );

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

    localparam isa_pkg::word_t START_PC = 32'h100;
    localparam int N_PROGS    = 8;
    localparam int N_RAND     = 48;
    localparam int N_DUMP     = 15;
    localparam int PROG_LEN   = N_RAND + N_DUMP + 1;   // Last word is the self-loop
    localparam int DUMP_BASE  = 32'h0800;
    localparam int MAX_CYCLES = N_PROGS * (N_RAND + N_DUMP) * 10;

    logic              clk;
    logic              reset = 1'b1;
    isa_pkg::word_t    inst_addr;
    isa_pkg::word_t    inst;
    pipe_pkg::wb_req_t wb_req;
    logic              wb_ack = 1'b0;

    integer            seed = 32'h504f;
    isa_pkg::word_t    rom [PROG_LEN];
    isa_pkg::word_t    rom_off;
    isa_pkg::word_t    exp_adr [$];    // Expected stores in program order
    isa_pkg::word_t    exp_dat [$];
    int                exp_wait [$];   // Wait states per store
    int                store_idx = 0;
    int                cycle_count = 0;
    logic              busy = 1'b0;
    int                wait_left = 0;
    isa_pkg::word_t    hold_adr;
    isa_pkg::word_t    hold_dat;

    isa_pkg::func_t    alu_funcs [14] = '{isa_pkg::EQ, isa_pkg::LT, isa_pkg::LE, isa_pkg::NE,
        isa_pkg::ADD, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::SUB, isa_pkg::NAND,
        isa_pkg::NOR, isa_pkg::NXOR, isa_pkg::RSHF, isa_pkg::LSHF};
    isa_pkg::opcode_t  imm_ops [4] = '{isa_pkg::ADDI, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI};
    isa_pkg::opcode_t  br_ops [4]  = '{isa_pkg::BEQ, isa_pkg::BLT, isa_pkg::BLE, isa_pkg::BNE};

    cpu_top #(.START_PC(START_PC)) UUT (
        .clk, .reset, .inst_addr, .inst, .wb_req, .wb_ack
    );

    // Fetches outside the program land on the self-loop
    assign rom_off = (inst_addr - START_PC) >> 2;
    assign inst    = (rom_off < PROG_LEN) ? rom[rom_off[5:0]] : rom[PROG_LEN - 1];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input isa_pkg::word_t got, input isa_pkg::word_t expected,
                               input string what);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            fail_run();
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    // Low registers favored so neighbors depend on each other
    function automatic isa_pkg::reg_idx_t pick_reg();
        if (rand_below(4) == 0)
            return 4'(rand_below(16));
        return 4'(rand_below(8));
    endfunction

    function automatic isa_pkg::word_t alur_word(input isa_pkg::func_t fn,
            input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt);
        return {isa_pkg::ALUR, fn, 6'b0, rd, rs, rt};
    endfunction

    function automatic isa_pkg::word_t imm_word(input isa_pkg::opcode_t op, input logic [15:0] imm,
            input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt);
        return {op, 2'b00, imm, rs, rt};
    endfunction

    function automatic isa_pkg::word_t alu_ref(input logic [7:0] fn, input isa_pkg::word_t a,
                                               input isa_pkg::word_t b);
        case (fn)
            isa_pkg::EQ:   return (a == b) ? 32'd1 : 32'd0;
            isa_pkg::LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::NE:   return (a != b) ? 32'd1 : 32'd0;
            isa_pkg::ADD:  return a + b;
            isa_pkg::AND:  return a & b;
            isa_pkg::OR:   return a | b;
            isa_pkg::XOR:  return a ^ b;
            isa_pkg::SUB:  return a - b;
            isa_pkg::NAND: return ~(a & b);
            isa_pkg::NOR:  return ~(a | b);
            isa_pkg::NXOR: return ~(a ^ b);
            isa_pkg::RSHF: return (b > 32'd31) ? {32{a[31]}} : isa_pkg::word_t'($signed(a) >>> b[4:0]);
            isa_pkg::LSHF: return (b > 32'd31) ? 32'd0 : a << b[4:0];
            default:       return 32'd0;
        endcase
    endfunction

    task automatic make_program();
        int                kind;
        int                room;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        logic [15:0]       imm;
        for (int i = 0; i < N_RAND; i++) begin
            kind = rand_below(20);
            room = N_RAND - 1 - i;   // Words a forward jump may skip
            rd   = pick_reg();
            rs   = pick_reg();
            rt   = pick_reg();
            imm  = (rand_below(2) == 1) ? 16'(rand_below(32)) : 16'(rand_below(65536));
            if (kind >= 13 && kind <= 16 && room == 0)
                kind = 7;
            if (kind <= 6)
                rom[6'(i)] = alur_word(alu_funcs[4'(rand_below(14))], rd, rs, rt);
            else if (kind <= 12)
                rom[6'(i)] = imm_word(imm_ops[2'(rand_below(4))], imm, rs, rt);
            else if (kind <= 15)
                rom[6'(i)] = imm_word(br_ops[2'(rand_below(4))],
                                      16'(1 + rand_below(room < 4 ? room : 4)), rs, rt);
            else if (kind == 16)
                rom[6'(i)] = imm_word(isa_pkg::JAL, 16'(START_PC / 4 +
                                      32'(i + 1 + rand_below(room < 4 ? room + 1 : 5))), 4'd0, rt);
            else
                rom[6'(i)] = imm_word(isa_pkg::SW, 16'(4 * rand_below(256)), rs, rt);
        end
        for (int k = 1; k <= N_DUMP; k++)
            rom[6'(N_RAND + k - 1)] = imm_word(isa_pkg::SW, 16'(DUMP_BASE + 4 * k), 4'd0, 4'(k));
        rom[PROG_LEN - 1] = imm_word(isa_pkg::BEQ, 16'hffff, 4'd0, 4'd0);   // Branch to self
    endtask

    // In-order ISA model, fills the expected store queue
    task automatic run_model();
        isa_pkg::word_t    regs [16];
        isa_pkg::word_t    w;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    result;
        isa_pkg::reg_idx_t dst;
        logic              writes;
        logic              taken;
        int                pc_idx;
        int                next_idx;
        for (int r = 0; r < 16; r++)
            regs[4'(r)] = '0;
        exp_adr.delete();
        exp_dat.delete();
        exp_wait.delete();
        pc_idx = 0;
        while (pc_idx < PROG_LEN - 1) begin
            w        = rom[6'(pc_idx)];
            a        = regs[w[7:4]];
            b        = regs[w[3:0]];
            imm      = {{16{w[23]}}, w[23:8]};
            dst      = w[3:0];
            writes   = !(w[31:26] inside {isa_pkg::BEQ, isa_pkg::BLT, isa_pkg::BLE,
                                          isa_pkg::BNE, isa_pkg::SW});
            result   = '0;
            taken    = 1'b0;
            next_idx = pc_idx + 1;
            case (w[31:26])
                isa_pkg::ALUR: begin
                    dst    = w[11:8];
                    result = alu_ref(w[25:18], a, b);
                end
                isa_pkg::ADDI: result = a + imm;
                isa_pkg::ANDI: result = a & imm;
                isa_pkg::ORI:  result = a | imm;
                isa_pkg::XORI: result = a ^ imm;
                isa_pkg::BEQ:  taken = (a == b);
                isa_pkg::BLT:  taken = ($signed(a) < $signed(b));
                isa_pkg::BLE:  taken = ($signed(a) <= $signed(b));
                isa_pkg::BNE:  taken = (a != b);
                isa_pkg::JAL: begin
                    result   = START_PC + 32'(4 * (pc_idx + 1));   // Link to next word
                    next_idx = int'((a + (imm << 2) - START_PC) >> 2);
                end
                isa_pkg::SW: begin
                    exp_adr.push_back(a + imm);
                    exp_dat.push_back(b);
                    exp_wait.push_back(rand_below(4));
                end
                default: writes = 1'b0;
            endcase
            if (taken)
                next_idx = pc_idx + 1 + int'($signed(imm));
            if (writes && dst != 4'd0)
                regs[dst] = result;
            pc_idx = next_idx;
        end
    endtask

    initial begin
        for (int p = 0; p < N_PROGS; p++) begin
            @(negedge clk);
            reset = 1'b1;
            make_program();
            run_model();
            repeat (5) @(negedge clk);
            check_equal(inst_addr, START_PC, "inst_addr after reset");
            check_equal(32'({wb_req.cyc, wb_req.stb}), 32'd0, "cyc and stb after reset");
            reset = 1'b0;
            while (store_idx < exp_adr.size())
                @(negedge clk);
            repeat (8) @(negedge clk);   // A repeated store would show up here
        end
        $display("Done: no errors");
        $finish;
    end

    // Wishbone slave
    always @(negedge clk) begin
        if (reset) begin
            wb_ack    = 1'b0;
            busy      = 1'b0;
            store_idx = 0;
        end else begin
            wb_ack = 1'b0;
            if (wb_req.stb && !busy && store_idx >= exp_adr.size()) begin
                $display("Store to %h at %0t ns was not expected", wb_req.adr, $time);
                fail_run();
            end else if (wb_req.stb) begin
                if (!busy) begin   // New request
                    busy      = 1'b1;
                    wait_left = exp_wait[store_idx];
                    hold_adr  = wb_req.adr;
                    hold_dat  = wb_req.dat;
                end
                check_equal(wb_req.adr, hold_adr, "adr during wait states");
                check_equal(wb_req.dat, hold_dat, "dat during wait states");
                if (wait_left == 0) begin
                    check_equal(32'({wb_req.cyc, wb_req.we}), 32'd3, "cyc and we");
                    check_equal(32'(wb_req.sel), 32'hf, "sel");
                    check_equal(wb_req.adr, exp_adr[store_idx], "store address");
                    check_equal(wb_req.dat, exp_dat[store_idx], "store data");
                    store_idx++;
                    busy   = 1'b0;
                    wb_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the stores did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

endmodule

//--- src.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
testbench/tb_cpu.sv

//--- Makefile
# Verilator simulation of the pipelined CPU

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_cpu \
		-f src.f -o sim_cpu
	./obj_dir/sim_cpu | awk '{print} /^Done: no errors$$/ {ok = 1} END {exit !ok}'

clean:
	rm -rf obj_dir
